// ==== include/invsqrt_macros.svh ====
// ####################################################################
// Constants for the reciprocal square root unit: fixed-point width,
// Newton-Raphson iteration count and special result words
// ####################################################################
`ifndef INVSQRT_MACROS_SVH
`define INVSQRT_MACROS_SVH

// Fraction bits of the internal estimate, two integer bits sit above
`define INVSQRT_FRAC_W 28

// Newton-Raphson iterations, valid range 2 to 5
`define INVSQRT_NR_ITERS 3

// Special result words
`define INVSQRT_QNAN 32'h7FC00000
`define INVSQRT_POS_INF 32'h7F800000

`endif

// ==== verilog/invsqrt_pkg.sv ====
// ####################################################################
// Shared types: fp32 word views, operand class and multiply phase
// ####################################################################
package invsqrt_pkg;

    // Field view of a single-precision word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp32_fields_t;

    // Same 32 bits seen either as a raw word or as fields
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t f;
    } fp32_t;

    // Operand class, decides between computed and substituted result
    typedef enum logic [2:0] {
        CLS_NORMAL,
        CLS_ZERO,
        CLS_INF,
        CLS_NAN,
        CLS_NEG
    } fp_class_e;

    // Operation of one multiply cycle within an iteration
    typedef enum logic [1:0] {
        PH_SQUARE,
        PH_SCALE,
        PH_UPDATE
    } nr_phase_e;

endpackage

// ==== verilog/nr_ctrl_if.sv ====
// ####################################################################
// Control strobes from the sequencing FSM to the datapath blocks
// ####################################################################
`timescale 1ns/10ps

interface nr_ctrl_if (
    input logic clk
);

    // One-cycle strobes
    logic capture;
    logic load_seed;
    logic pack_en;

    // High on every multiply cycle, phase names the operation
    logic                    mul_en;
    invsqrt_pkg::nr_phase_e  phase;

    modport ctrl (input clk, output capture, load_seed, mul_en, phase, pack_en);

    modport unpack_mp (input clk, input capture);

    modport dp_mp (input clk, input load_seed, mul_en, phase);

    modport pack_mp (input clk, input pack_en);

endinterface

// ==== verilog/invsqrt_unpack.sv ====
// ####################################################################
// Operand capture, classification, exponent halving, mantissa
// alignment and the seed table for the first estimate
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module invsqrt_unpack (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [31:0]                   operand,
    nr_ctrl_if.unpack_mp                  ctrl,
    output invsqrt_pkg::fp_class_e        op_class,
    output logic [8:0]                    exp_out,
    output logic [`INVSQRT_FRAC_W+1:0]    half_mant,
    output logic [`INVSQRT_FRAC_W+1:0]    seed
);

    localparam int FW      = `INVSQRT_FRAC_W;
    localparam int SIG_W   = FW + 2;
    localparam int SEED_FW = 12;

    invsqrt_pkg::fp32_t      op_word;
    invsqrt_pkg::fp_class_e  cls_next;
    logic                    exp_even;
    logic [8:0]              exp_diff;
    logic [SIG_W-1:0]        sig_aligned;
    logic [SIG_W-1:0]        half_next;
    logic [12:0]             seed_q;

    assign op_word = operand;

    // Subnormals have exponent field 0 and fall into the zero class
    always_comb begin
        if (op_word.f.exp == 8'h00) begin
            cls_next = invsqrt_pkg::CLS_ZERO;
        end else if (op_word.f.exp == 8'hFF) begin
            cls_next = (op_word.f.mant != 23'd0) ? invsqrt_pkg::CLS_NAN : invsqrt_pkg::CLS_INF;
        end else if (op_word.f.sign) begin
            cls_next = invsqrt_pkg::CLS_NEG;
        end else begin
            cls_next = invsqrt_pkg::CLS_NORMAL;
        end
    end

    // Even biased exponent means an odd unbiased one, so the significand
    // takes one extra right shift to make the remaining power even
    assign exp_even    = ~op_word.f.exp[0];
    assign exp_diff    = 9'd381 - {1'b0, op_word.f.exp};
    assign sig_aligned = {2'b01, op_word.f.mant, {(FW-23){1'b0}}};
    assign half_next   = exp_even ? (sig_aligned >> 2) : (sig_aligned >> 1);

    // Seed is 1/sqrt at the geometric middle of each segment, 12 fraction bits
    always_comb begin
        case ({op_word.f.exp[0], op_word.f.mant[22:20]})
            4'b0_000: seed_q = 13'd5624;
            4'b0_001: seed_q = 13'd5319;
            4'b0_010: seed_q = 13'd5059;
            4'b0_011: seed_q = 13'd4834;
            4'b0_100: seed_q = 13'd4636;
            4'b0_101: seed_q = 13'd4461;
            4'b0_110: seed_q = 13'd4304;
            4'b0_111: seed_q = 13'd4163;
            4'b1_000: seed_q = 13'd3977;
            4'b1_001: seed_q = 13'd3761;
            4'b1_010: seed_q = 13'd3577;
            4'b1_011: seed_q = 13'd3418;
            4'b1_100: seed_q = 13'd3278;
            4'b1_101: seed_q = 13'd3154;
            4'b1_110: seed_q = 13'd3043;
            default:  seed_q = 13'd2943;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_class  <= invsqrt_pkg::CLS_ZERO;
            exp_out   <= '0;
            half_mant <= '0;
            seed      <= '0;
        end else if (ctrl.capture) begin
            op_class  <= cls_next;
            exp_out   <= {1'b0, exp_diff[8:1]};
            half_mant <= half_next;
            seed      <= SIG_W'(seed_q) << (FW - SEED_FW);
        end
    end

endmodule

// ==== verilog/nr_iter_counter.sv ====
// ####################################################################
// Phase and iteration counter with the final update flag
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module nr_iter_counter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clear,
    input  logic                    advance,
    output invsqrt_pkg::nr_phase_e  phase,
    output logic                    last_step
);

    localparam int ITER_W = $clog2(`INVSQRT_NR_ITERS + 1);
    localparam logic [ITER_W-1:0] ITER_LAST = ITER_W'(`INVSQRT_NR_ITERS - 1);

    logic [ITER_W-1:0] iter;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= invsqrt_pkg::PH_SQUARE;
            iter  <= '0;
        end else if (clear) begin
            phase <= invsqrt_pkg::PH_SQUARE;
            iter  <= '0;
        end else if (advance) begin
            case (phase)
                invsqrt_pkg::PH_SQUARE: phase <= invsqrt_pkg::PH_SCALE;
                invsqrt_pkg::PH_SCALE:  phase <= invsqrt_pkg::PH_UPDATE;
                default: begin
                    phase <= invsqrt_pkg::PH_SQUARE;
                    iter  <= (iter == ITER_LAST) ? '0 : iter + 1'b1;
                end
            endcase
        end
    end

    assign last_step = (phase == invsqrt_pkg::PH_UPDATE) && (iter == ITER_LAST);

endmodule

// ==== verilog/invsqrt_ctrl_fsm.sv ====
// ####################################################################
// Sequencing FSM: capture, seed load, iterations, pack, busy and done
// ####################################################################
`timescale 1ns/10ps

module invsqrt_ctrl_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic                    last_step,
    output logic                    cnt_clear,
    output logic                    cnt_advance,
    input  invsqrt_pkg::nr_phase_e  phase_in,
    nr_ctrl_if.ctrl                 ctrl,
    output logic                    busy,
    output logic                    done
);

    typedef enum logic [2:0] {IDLE, CAPTURE, SEED, ITERATE, PACK} state_e;

    state_e state;
    state_e state_next;
    logic   start_ok;

    // A start is taken only from IDLE, which is exactly when busy is low
    assign start_ok = (state == IDLE) && start;

    always_comb begin
        case (state)
            IDLE:    state_next = start_ok ? CAPTURE : IDLE;
            CAPTURE: state_next = SEED;
            SEED:    state_next = ITERATE;
            ITERATE: state_next = last_step ? PACK : ITERATE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            done  <= (state == PACK);
            if (start_ok) begin
                busy <= 1'b1;
            end else if (state == PACK) begin
                busy <= 1'b0;
            end
        end
    end

    assign ctrl.capture   = (state == CAPTURE);
    assign ctrl.load_seed = (state == SEED);
    assign ctrl.mul_en    = (state == ITERATE);
    assign ctrl.phase     = phase_in;
    assign ctrl.pack_en   = (state == PACK);

    // Counter restarts while the seed loads, then steps on every multiply
    assign cnt_clear   = (state == SEED);
    assign cnt_advance = (state == ITERATE);

endmodule

// ==== verilog/nr_mul_datapath.sv ====
// ####################################################################
// Shared multiplier with estimate and temporary registers running the
// three-phase Newton-Raphson step y = y * (1.5 - (x/2) * y^2)
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module nr_mul_datapath (
    input  logic                          clk,
    input  logic                          arst_n,
    nr_ctrl_if.dp_mp                      ctrl,
    input  logic [`INVSQRT_FRAC_W+1:0]    half_mant,
    input  logic [`INVSQRT_FRAC_W+1:0]    seed,
    output logic [`INVSQRT_FRAC_W+1:0]    y_est
);

    localparam int FW = `INVSQRT_FRAC_W;
    localparam int W  = FW + 2;

    // 1.5 in the unsigned 2.FW format
    localparam logic [W-1:0] THREE_HALF = W'(3) << (FW - 1);

    logic [W-1:0]   y;
    logic [W-1:0]   t;
    logic [W-1:0]   mul_a;
    logic [W-1:0]   mul_b;
    logic [2*W-1:0] product;
    logic [W-1:0]   prod_trunc;

    // Operand select for the one multiplier
    always_comb begin
        case (ctrl.phase)
            invsqrt_pkg::PH_SQUARE: begin
                mul_a = y;
                mul_b = y;
            end
            invsqrt_pkg::PH_SCALE: begin
                mul_a = half_mant;
                mul_b = t;
            end
            default: begin
                // t stays near 0.5 here, so the difference never wraps
                mul_a = y;
                mul_b = THREE_HALF - t;
            end
        endcase
    end

    assign product = mul_a * mul_b;

    // Drop the low FW fraction bits, all products stay below 4
    assign prod_trunc = product[FW +: W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y <= '0;
            t <= '0;
        end else if (ctrl.load_seed) begin
            y <= seed;
        end else if (ctrl.mul_en) begin
            if (ctrl.phase == invsqrt_pkg::PH_UPDATE) begin
                y <= prod_trunc;
            end else begin
                t <= prod_trunc;
            end
        end
    end

    assign y_est = y;

endmodule

// ==== verilog/invsqrt_pack.sv ====
// ####################################################################
// Result normalization, truncation, special values and result register
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module invsqrt_pack (
    input  logic                          clk,
    input  logic                          arst_n,
    nr_ctrl_if.pack_mp                    ctrl,
    input  invsqrt_pkg::fp_class_e        op_class,
    input  logic [8:0]                    exp_out,
    input  logic [`INVSQRT_FRAC_W+1:0]    y_est,
    output logic [31:0]                   result
);

    localparam int FW = `INVSQRT_FRAC_W;

    invsqrt_pkg::fp32_t  norm_word;
    logic [8:0]          exp_norm;
    logic [22:0]         mant_norm;

    // Estimate lies in (0.7, 1.42), so at most one left shift is needed
    always_comb begin
        if (y_est[FW]) begin
            exp_norm  = exp_out;
            mant_norm = y_est[FW-1 -: 23];
        end else begin
            exp_norm  = exp_out - 9'd1;
            mant_norm = y_est[FW-2 -: 23];
        end
        norm_word.f.sign = 1'b0;
        norm_word.f.exp  = exp_norm[7:0];
        norm_word.f.mant = mant_norm;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (ctrl.pack_en) begin
            case (op_class)
                invsqrt_pkg::CLS_NAN,
                invsqrt_pkg::CLS_NEG:  result <= `INVSQRT_QNAN;
                invsqrt_pkg::CLS_INF:  result <= 32'h0000_0000;
                invsqrt_pkg::CLS_ZERO: result <= `INVSQRT_POS_INF;
                default:               result <= norm_word.raw;
            endcase
        end
    end

endmodule

// ==== verilog/invsqrt_top.sv ====
// ####################################################################
// Multi-cycle fp32 reciprocal square root, top level
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module invsqrt_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic [31:0] operand,
    output logic        busy,
    output logic        done,
    output logic [31:0] result
);

    logic                            last_step;
    logic                            cnt_clear;
    logic                            cnt_advance;
    invsqrt_pkg::nr_phase_e          phase;
    invsqrt_pkg::fp_class_e          op_class;
    logic [8:0]                      exp_out;
    logic [`INVSQRT_FRAC_W+1:0]      half_mant;
    logic [`INVSQRT_FRAC_W+1:0]      seed;
    logic [`INVSQRT_FRAC_W+1:0]      y_est;

    nr_ctrl_if u_ctrl_if (.clk(clk));

    invsqrt_ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .last_step   (last_step),
        .cnt_clear   (cnt_clear),
        .cnt_advance (cnt_advance),
        .phase_in    (phase),
        .ctrl        (u_ctrl_if.ctrl),
        .busy        (busy),
        .done        (done)
    );

    nr_iter_counter u_iter_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (cnt_clear),
        .advance   (cnt_advance),
        .phase     (phase),
        .last_step (last_step)
    );

    invsqrt_unpack u_unpack (
        .clk       (clk),
        .arst_n    (arst_n),
        .operand   (operand),
        .ctrl      (u_ctrl_if.unpack_mp),
        .op_class  (op_class),
        .exp_out   (exp_out),
        .half_mant (half_mant),
        .seed      (seed)
    );

    nr_mul_datapath u_mul_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (u_ctrl_if.dp_mp),
        .half_mant (half_mant),
        .seed      (seed),
        .y_est     (y_est)
    );

    invsqrt_pack u_pack (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (u_ctrl_if.pack_mp),
        .op_class (op_class),
        .exp_out  (exp_out),
        .y_est    (y_est),
        .result   (result)
    );

endmodule

// ==== dv/invsqrt_props.sv ====
// ####################################################################
// Bound concurrent assertions on done, busy and result timing
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module invsqrt_props (
    input logic        clk,
    input logic        arst_n,
    input logic        start,
    input logic        busy,
    input logic        done,
    input logic [31:0] result
);

    localparam int LATENCY = 3 * `INVSQRT_NR_ITERS + 3;
    // Done changes on the last edge and is first seen one sample later
    localparam int SAMPLE_LAG = LATENCY + 1;

    logic accepted;

    assign accepted = start && !busy;

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    start_to_done: assert property (@(posedge clk) disable iff (!arst_n)
        $past(accepted, SAMPLE_LAG) |-> done)
        else $error("done missing after an accepted start");

    done_from_start: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(accepted, SAMPLE_LAG))
        else $error("done without an accepted start at the fixed latency");

    // Out of reset busy stays low until a start is accepted
    idle_until_start: assert property (@(posedge clk) disable iff (!arst_n)
        (!busy && !accepted) |=> !busy)
        else $error("busy rose without an accepted start");

    // Result holds between operations
    result_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (!busy && !$past(busy)) |-> $stable(result))
        else $error("result changed while idle");

endmodule

bind invsqrt_top invsqrt_props u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .result (result)
);

// ==== dv/invsqrt_tb.sv ====
// ####################################################################
// Testbench for the fp32 reciprocal square root unit: table, timing,
// ignored and back-to-back starts, random operands with a real model
// ####################################################################
`timescale 1ns/10ps
`include "invsqrt_macros.svh"

module invsqrt_tb;

    localparam int  LATENCY  = 3 * `INVSQRT_NR_ITERS + 3;
    localparam int  TIMEOUT  = 40;
    localparam int  NUM_VEC  = 18;
    localparam int  NUM_RAND = 200;
    localparam real TOL      = 1.0 / 2097152.0;

    // Operand, exact flag and the exact word where the flag is set
    typedef struct packed {
        logic [31:0] op;
        logic        exact;
        logic [31:0] expect_word;
    } vec_t;

    logic        clk;
    logic        arst_n;
    logic        start;
    logic [31:0] operand;
    logic        busy;
    logic        done;
    logic [31:0] result;

    int seed         = 73;
    int errors       = 0;
    int tests        = 0;
    int failed_tests = 0;

    vec_t vectors [NUM_VEC] = '{
        '{32'h3F800000, 1'b0, 32'h0}, '{32'h40800000, 1'b0, 32'h0},
        '{32'h3E800000, 1'b0, 32'h0}, '{32'h40000000, 1'b0, 32'h0},
        '{32'h40400000, 1'b0, 32'h0}, '{32'h0DA24260, 1'b0, 32'h0},
        '{32'h7149F2CA, 1'b0, 32'h0}, '{32'h407FFFFF, 1'b0, 32'h0},
        '{32'h3E7FFFFF, 1'b0, 32'h0}, '{32'h417FFFFF, 1'b0, 32'h0},
        '{32'h3F7FFFFF, 1'b0, 32'h0},
        '{32'h00000000, 1'b1, `INVSQRT_POS_INF}, '{32'h80000000, 1'b1, `INVSQRT_POS_INF},
        '{32'h7F800000, 1'b1, 32'h00000000},     '{32'hFF800000, 1'b1, 32'h00000000},
        '{32'h7FA00000, 1'b1, `INVSQRT_QNAN},    '{32'hC0000000, 1'b1, `INVSQRT_QNAN},
        '{32'h00400000, 1'b1, `INVSQRT_POS_INF}
    };

    invsqrt_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .operand (operand),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic real pow2(input int e);
        real p;
        int  k;
        p = 1.0;
        for (k = 0; k < e; k++) p = p * 2.0;
        for (k = 0; k < -e; k++) p = p / 2.0;
        return p;
    endfunction

    // Subnormals read as zero, same as the unit sees them
    function automatic real fp_to_real(input logic [31:0] word);
        invsqrt_pkg::fp32_t w;
        real                mag;
        w.raw = word;
        if (w.f.exp == 8'h00) begin
            mag = 0.0;
        end else begin
            mag = (1.0 + real'(w.f.mant) / 8388608.0) * pow2(int'(w.f.exp) - 127);
        end
        return w.f.sign ? -mag : mag;
    endfunction

    task automatic value_error(input string sig, input int expected, input int actual);
        $display("Error: time %0t signal %s expected %0d actual %0d", $time, sig, expected, actual);
        errors++;
    endtask

    task automatic launch(input logic [31:0] op);
        @(posedge clk);
        start   <= 1'b1;
        operand <= op;
        @(posedge clk);
        start   <= 1'b0;
    endtask

    // Counts clock edges from the start edge to done, optionally pulsing start at a given count
    task automatic wait_done(input int poke_at, input logic [31:0] poke_op, input bit poke_hold,
                             output int cycles, output logic [31:0] res, output bit timed_out);
        bit found;
        found  = 1'b0;
        cycles = 0;
        res    = '0;
        while (!found && cycles < TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                found = 1'b1;
                res   = result;
                assert (!busy) else value_error("busy", 0, busy);
            end else begin
                assert (busy || cycles >= LATENCY) else value_error("busy", 1, busy);
                if (cycles == poke_at) begin
                    @(posedge clk);
                    start   <= 1'b1;
                    operand <= poke_op;
                end else if (poke_at >= 0 && cycles == poke_at + 1 && !poke_hold) begin
                    @(posedge clk);
                    start <= 1'b0;
                end
                cycles++;
            end
        end
        timed_out = !found;
    endtask

    task automatic check_op(input logic [31:0] op, input bit exact, input logic [31:0] expect_word,
                            input logic [31:0] res, input int cycles, input bit timed_out);
        real want;
        real got;
        real rel;
        if (timed_out) begin
            $display("Timeout: done did not rise within %0d cycles for operand %h", TIMEOUT, op);
            errors++;
        end else begin
            assert (cycles == LATENCY) else value_error("done latency", LATENCY, cycles);
            if (exact) begin
                assert (res == expect_word) else begin
                    $display("Error: time %0t signal result expected %h actual %h",
                             $time, expect_word, res);
                    errors++;
                end
            end else begin
                want = 1.0 / $sqrt(fp_to_real(op));
                got  = fp_to_real(res);
                rel  = (got - want) / want;
                if (rel < 0.0) rel = -rel;
                assert (rel < TOL) else begin
                    $display("Error: time %0t signal result expected %e actual %e (%h)",
                             $time, want, got, res);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string what, input logic [31:0] op, input logic [31:0] res,
                               input int err_before);
        tests++;
        if (errors != err_before) failed_tests++;
        $display("test %0d %s operand %h result %h %s", tests, what, op, res,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic run_one(input string what, input logic [31:0] op, input bit exact,
                           input logic [31:0] expect_word);
        int          cycles;
        logic [31:0] res;
        bit          timed_out;
        int          err_before;
        err_before = errors;
        launch(op);
        wait_done(-1, 32'h0, 1'b0, cycles, res, timed_out);
        check_op(op, exact, expect_word, res, cycles, timed_out);
        @(negedge clk);
        assert (!done) else value_error("done", 0, done);
        report_test(what, op, res, err_before);
    endtask

    initial begin
        int                 i;
        int                 cycles;
        int                 err_before;
        bit                 timed_out;
        logic [31:0]        res_a;
        logic [31:0]        res_b;
        invsqrt_pkg::fp32_t rnd_word;

        arst_n  = 1'b0;
        start   = 1'b0;
        operand = 32'h0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        err_before = errors;
        @(negedge clk);
        assert (!busy && !done) else value_error("busy/done", 0, {busy, done});
        assert (result == 32'h0) else value_error("result", 0, result);
        report_test("reset", 32'h0, result, err_before);

        for (i = 0; i < NUM_VEC; i++) begin
            run_one("table", vectors[i].op, vectors[i].exact, vectors[i].expect_word);
        end

        // Start pulsed mid-operation with an operand that would give +inf
        err_before = errors;
        launch(32'h40800000);
        wait_done(4, 32'h00000000, 1'b0, cycles, res_a, timed_out);
        check_op(32'h40800000, 1'b0, 32'h0, res_a, cycles, timed_out);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!done) else value_error("done", 0, done);
        end
        report_test("ignored start", 32'h40800000, res_a, err_before);

        // Second start lands in the done cycle of the first
        err_before = errors;
        launch(32'h40400000);
        wait_done(LATENCY - 1, 32'h41100000, 1'b1, cycles, res_a, timed_out);
        check_op(32'h40400000, 1'b0, 32'h0, res_a, cycles, timed_out);
        @(posedge clk);
        start <= 1'b0;
        wait_done(-1, 32'h0, 1'b0, cycles, res_b, timed_out);
        check_op(32'h41100000, 1'b0, 32'h0, res_b, cycles, timed_out);
        @(negedge clk);
        assert (!done) else value_error("done", 0, done);
        report_test("back-to-back", 32'h41100000, res_b, err_before);

        for (i = 0; i < NUM_RAND; i++) begin
            rnd_word.raw    = $random(seed);
            rnd_word.f.sign = 1'b0;
            rnd_word.f.exp  = 8'd1 + 8'($unsigned($random(seed)) % 254);
            run_one("random", rnd_word.raw, 1'b0, 32'h0);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== invsqrt_top.f ====
+incdir+include
verilog/invsqrt_pkg.sv
verilog/nr_ctrl_if.sv
verilog/invsqrt_unpack.sv
verilog/nr_iter_counter.sv
verilog/invsqrt_ctrl_fsm.sv
verilog/nr_mul_datapath.sv
verilog/invsqrt_pack.sv
verilog/invsqrt_top.sv
dv/invsqrt_props.sv
dv/invsqrt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the reciprocal square root testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f invsqrt_top.f --top-module invsqrt_tb \
    -Mdir obj_dir -o invsqrt_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/invsqrt_sim > "$LOG" 2>&1 \
    || echo "Simulator returned a nonzero status"

grep -q "TEST FAIL" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "TEST PASS" "$LOG" || { echo "No pass line found in $LOG"; exit 1; }
echo "Simulation passed"
